// ==== design/rdm_pkg.sv ====
// The top level ROW_W must equal one ping-pong bit plus ADDR_W minus BANK_SEL_W. Sizes are count minus one
package rdm_pkg;

	//////////////////////////////
	// Widths and counts
	//////////////////////////////

	parameter int NUM_USERS_MAX = 8;   // Most users in one slot
	parameter int USER_IDX_W    = 4;
	parameter int BANK_NUM      = 16;  // Banks per row
	parameter int BANK_SEL_W    = 4;   // Low address bits that pick the bank
	parameter int BANK_DATA_W   = 48;
	parameter int LLR_W         = 6;   // One soft bit
	parameter int DEMUX_W       = 96;  // Up to two layers of qm 8
	parameter int ADDR_W        = 14;  // Linear position inside one ping-pong half

	//////////////////////////////
	// Types
	//////////////////////////////

	// Linear buffer position. Row is bits 13:4 and bank is bits 3:0
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [15:0] size_t;       // E0/E1 size as count minus one

	typedef logic [7:0] cb_cnt_t;

	typedef logic [3:0] qm_t;          // Modulation order

	typedef logic [USER_IDX_W-1:0] user_idx_t;

	typedef logic [BANK_DATA_W-1:0] bank_word_t;

	// Bank 0 sits in the low bits
	typedef logic [BANK_NUM*BANK_DATA_W-1:0] row_data_t;

endpackage

// ==== design/rdm_start_calc.sv ====
// Offsets are valid and o_start_load pulses 8 cycles after a slot start. E1 regions must fit in 14 bits
module rdm_start_calc #(
	parameter int NUM_USERS = 8
) (
	input  logic                            i_core_clk,
	input  logic                            i_rx_rstn,
	input  logic                            i_rdm_slot_start,
	input  rdm_pkg::size_t [NUM_USERS-1:0]  i_users_e1_sz,
	output rdm_pkg::addr_t [NUM_USERS-1:0]  o_start_offset,
	output logic                            o_start_load
);
	import rdm_pkg::*;

	localparam int STEP_W = $clog2(NUM_USERS_MAX);

	logic [STEP_W-1:0] step;
	logic              busy;
	addr_t             sum;   // Running sum of the regions walked so far

	// Region of one user, rounded up to whole rows
	function automatic addr_t region(input size_t sz);
		return addr_t'({sz[$bits(size_t)-1:BANK_SEL_W] + 1'b1, {BANK_SEL_W{1'b0}}});
	endfunction

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			step           <= '0;
			busy           <= 1'b0;
			sum            <= '0;
			o_start_offset <= '0;
			o_start_load   <= 1'b0;
		end
		else
		begin
			o_start_load <= 1'b0;
			if (i_rdm_slot_start)
			begin
				o_start_offset[0] <= '0;   // User 0 always at the bottom
				sum               <= region(i_users_e1_sz[0]);
				step              <= STEP_W'(1);
				busy              <= 1'b1;
			end
			else if (busy)
			begin
				// One user per cycle
				for (int u = 1; u < NUM_USERS; u++)
				begin
					if (step == STEP_W'(u))
					begin
						o_start_offset[u] <= sum;
						sum               <= sum + region(i_users_e1_sz[u]);
					end
				end
				// Fixed walk over the full user range keeps the load timing constant
				if (step == STEP_W'(NUM_USERS_MAX - 1))
				begin
					busy         <= 1'b0;
					o_start_load <= 1'b1;
				end
				step <= step + 1'b1;
			end
		end
	end

endmodule

// ==== design/rdm_write_tracker.sv ====
// Strobes with a user index of NUM_USERS or more are dropped. Offsets must be loaded before the first strobe
module rdm_write_tracker #(
	parameter int NUM_USERS = 8,
	parameter int ROW_W     = 11
) (
	input  logic                              i_core_clk,
	input  logic                              i_rx_rstn,
	input  logic                              i_rdm_slot_start,
	input  rdm_pkg::addr_t   [NUM_USERS-1:0]  i_start_offset,
	input  logic                              i_start_load,
	input  rdm_pkg::size_t   [NUM_USERS-1:0]  i_users_e0_sz,
	input  rdm_pkg::size_t   [NUM_USERS-1:0]  i_users_e1_sz,
	input  rdm_pkg::cb_cnt_t [NUM_USERS-1:0]  i_users_e0_num,
	input  logic             [NUM_USERS-1:0]  i_layer_indicator,
	input  logic                              i_demux_strb,
	input  rdm_pkg::user_idx_t                i_demux_user_idx,
	output logic                              o_wr_strb,
	output logic [ROW_W-1:0]                  o_wr_row,
	output logic [rdm_pkg::BANK_SEL_W-1:0]    o_wr_bank_sel,
	output logic [NUM_USERS-1:0]              o_ping_pong,
	output logic                              o_cb_done,
	output rdm_pkg::user_idx_t                o_cb_user,
	output rdm_pkg::addr_t                    o_cb_size
);
	import rdm_pkg::*;

	// Per-user state
	addr_t   [NUM_USERS-1:0] pos_cnt;    // Position inside the current code block
	cb_cnt_t [NUM_USERS-1:0] cb_cnt;
	addr_t   [NUM_USERS-1:0] addr_tot;   // Offset plus position

	// State of the user addressed by the strobe
	logic [NUM_USERS-1:0] user_sel;
	addr_t                cur_cnt;
	addr_t                cur_tot;
	logic                 cur_pp;
	size_t                cur_lim;
	addr_t                cur_step;
	logic                 cur_wrap;

	//////////////////////////////
	// User select
	//////////////////////////////

	always_comb
	begin
		user_sel = '0;
		cur_cnt  = '0;
		cur_tot  = '0;
		cur_pp   = 1'b0;
		cur_lim  = '0;
		cur_step = '0;
		for (int u = 0; u < NUM_USERS; u++)
		begin
			if (i_demux_user_idx == user_idx_t'(u))
			begin
				user_sel[u] = 1'b1;
				cur_cnt     = pos_cnt[u];
				cur_tot     = addr_tot[u];
				cur_pp      = o_ping_pong[u];
				// E0 size until E0 count blocks are done
				cur_lim     = (cb_cnt[u] < i_users_e0_num[u]) ? i_users_e0_sz[u] : i_users_e1_sz[u];
				cur_step    = i_layer_indicator[u] ? addr_t'(2) : addr_t'(1);
			end
		end
	end

	assign cur_wrap      = size_t'(cur_cnt) >= cur_lim;
	assign o_wr_strb     = i_demux_strb & (|user_sel);
	assign o_wr_row      = {cur_pp, cur_tot[BANK_SEL_W +: ROW_W-1]};   // Pre-update position
	assign o_wr_bank_sel = cur_tot[BANK_SEL_W-1:0];

	//////////////////////////////
	// Position and ping-pong
	//////////////////////////////

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			pos_cnt     <= '0;
			cb_cnt      <= '0;
			addr_tot    <= '0;
			o_ping_pong <= '0;
		end
		else
		begin
			for (int u = 0; u < NUM_USERS; u++)
			begin
				if (i_rdm_slot_start)
				begin
					pos_cnt[u] <= '0;   // Ping-pong bit carries over to the next slot
					cb_cnt[u]  <= '0;
				end
				else if (o_wr_strb && user_sel[u])
				begin
					if (cur_wrap)
					begin
						pos_cnt[u]     <= '0;
						cb_cnt[u]      <= cb_cnt[u] + 1'b1;
						o_ping_pong[u] <= ~o_ping_pong[u];
					end
					else
					begin
						pos_cnt[u] <= cur_cnt + cur_step;
					end
				end

				if (i_start_load)
				begin
					addr_tot[u] <= i_start_offset[u];
				end
				else if (o_wr_strb && user_sel[u])
				begin
					addr_tot[u] <= cur_wrap ? i_start_offset[u] : cur_tot + cur_step;
				end
			end
		end
	end

	// Completion report, one cycle after the wrapping strobe
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			o_cb_done <= 1'b0;
			o_cb_user <= '0;
			o_cb_size <= '0;
		end
		else
		begin
			o_cb_done <= o_wr_strb & cur_wrap;
			if (o_wr_strb && cur_wrap)
			begin
				o_cb_user <= i_demux_user_idx;
				o_cb_size <= cur_cnt;   // Held until the next completion
			end
		end
	end

endmodule

// ==== design/rdm_write_formatter.sv ====
// Two-layer words are valid only for qm 1, 2, 4, 6 and 8. Any other qm writes zeros to the bank pair
module rdm_write_formatter #(
	parameter int NUM_USERS = 8,
	parameter int ROW_W     = 11
) (
	input  logic                           i_wr_strb,
	input  logic [ROW_W-1:0]               i_wr_row,
	input  logic [rdm_pkg::BANK_SEL_W-1:0] i_wr_bank_sel,
	input  rdm_pkg::user_idx_t             i_demux_user_idx,
	input  logic [rdm_pkg::DEMUX_W-1:0]    i_demux_rx,
	input  logic [NUM_USERS-1:0]           i_layer_indicator,
	input  rdm_pkg::qm_t [NUM_USERS-1:0]   i_users_qm,
	output logic [rdm_pkg::BANK_NUM-1:0]   o_bank_we,
	output logic [ROW_W-1:0]               o_bank_row,
	output rdm_pkg::row_data_t             o_bank_data
);
	import rdm_pkg::*;

	logic                two_layer;
	qm_t                 qm;
	logic                qm_ok;
	int                  layer_w;      // Soft bits of one layer times LLR_W
	logic [DEMUX_W-1:0]  layer_mask;
	bank_word_t          lo_word;
	bank_word_t          hi_word;

	// Layer mode and qm of the strobing user
	always_comb
	begin
		two_layer = 1'b0;
		qm        = '0;
		for (int u = 0; u < NUM_USERS; u++)
		begin
			if (i_demux_user_idx == user_idx_t'(u))
			begin
				two_layer = i_layer_indicator[u];
				qm        = i_users_qm[u];
			end
		end
	end

	//////////////////////////////
	// Bank words
	//////////////////////////////

	always_comb
	begin
		layer_w    = LLR_W * int'(qm);
		layer_mask = (DEMUX_W'(1) << layer_w) - DEMUX_W'(1);
		lo_word    = bank_word_t'(i_demux_rx & layer_mask);
		hi_word    = bank_word_t'((i_demux_rx >> layer_w) & layer_mask);
		qm_ok      = qm inside {4'd1, 4'd2, 4'd4, 4'd6, 4'd8};

		if (!two_layer)
			o_bank_data = {BANK_NUM{i_demux_rx[BANK_DATA_W-1:0]}};
		else if (qm_ok)
			o_bank_data = {(BANK_NUM/2){hi_word, lo_word}};   // Even bank low layer
		else
			o_bank_data = '0;
	end

	// One-hot for a single layer, pair-hot for two
	always_comb
	begin
		if (!i_wr_strb)
			o_bank_we = '0;
		else if (two_layer)
			o_bank_we = BANK_NUM'(2'b11) << {i_wr_bank_sel[BANK_SEL_W-1:1], 1'b0};
		else
			o_bank_we = BANK_NUM'(1'b1) << i_wr_bank_sel;
	end

	assign o_bank_row = i_wr_row;

endmodule

// ==== design/rdm_input_buffer.sv ====
// Read data lags the read row by one cycle. A same-row read during a write returns the old word
module rdm_input_buffer #(
	parameter int ROW_W = 11
) (
	input  logic                          i_core_clk,
	input  logic [rdm_pkg::BANK_NUM-1:0]  i_bank_we,
	input  logic [ROW_W-1:0]              i_bank_row,
	input  rdm_pkg::row_data_t            i_bank_data,
	input  logic [ROW_W-1:0]              i_rd_row,
	output wire rdm_pkg::row_data_t       o_rd_data
);
	import rdm_pkg::*;

	//////////////////////////////
	// One memory per bank
	//////////////////////////////

	for (genvar b = 0; b < BANK_NUM; b++)
	begin : g_bank
		bank_word_t mem [2**ROW_W];
		bank_word_t rd_q;

		always_ff @(posedge i_core_clk)
		begin
			if (i_bank_we[b])
			begin
				mem[i_bank_row] <= i_bank_data[b*BANK_DATA_W +: BANK_DATA_W];
			end
			rd_q <= mem[i_rd_row];
		end

		assign o_rd_data[b*BANK_DATA_W +: BANK_DATA_W] = rd_q;
	end

endmodule

// ==== design/rdm_input_top.sv ====
// No back-pressure. Element strobes must start at least 10 cycles after i_rdm_slot_start
module rdm_input_top #(
	parameter int NUM_USERS = 8,
	parameter int ROW_W     = 11
) (
	input  logic                              i_core_clk,
	input  logic                              i_rx_rstn,
	input  logic                              i_rdm_slot_start,
	input  rdm_pkg::size_t   [NUM_USERS-1:0]  i_users_e0_sz,
	input  rdm_pkg::size_t   [NUM_USERS-1:0]  i_users_e1_sz,
	input  rdm_pkg::cb_cnt_t [NUM_USERS-1:0]  i_users_e0_num,
	input  logic             [NUM_USERS-1:0]  i_layer_indicator,
	input  rdm_pkg::qm_t     [NUM_USERS-1:0]  i_users_qm,
	input  logic                              i_demux_strb,
	input  rdm_pkg::user_idx_t                i_demux_user_idx,
	input  logic [rdm_pkg::DEMUX_W-1:0]       i_demux_rx,
	input  logic [ROW_W-1:0]                  i_rd_row,
	output rdm_pkg::row_data_t                o_rd_data,
	output logic [NUM_USERS-1:0]              o_ping_pong,
	output logic                              o_cb_done,
	output rdm_pkg::user_idx_t                o_cb_user,
	output rdm_pkg::addr_t                    o_cb_size
);
	import rdm_pkg::*;

	addr_t [NUM_USERS-1:0]  start_offset;
	logic                   start_load;
	logic                   wr_strb;
	logic [ROW_W-1:0]       wr_row;
	logic [BANK_SEL_W-1:0]  wr_bank_sel;
	logic [BANK_NUM-1:0]    bank_we;
	logic [ROW_W-1:0]       bank_row;
	row_data_t              bank_data;

	//////////////////////////////
	// Input side
	//////////////////////////////

	rdm_start_calc #(
		.NUM_USERS (NUM_USERS)
	) u_start_calc (
		.i_core_clk       (i_core_clk),
		.i_rx_rstn        (i_rx_rstn),
		.i_rdm_slot_start (i_rdm_slot_start),
		.i_users_e1_sz    (i_users_e1_sz),
		.o_start_offset   (start_offset),
		.o_start_load     (start_load)
	);

	//////////////////////////////
	// Processing
	//////////////////////////////

	rdm_write_tracker #(
		.NUM_USERS (NUM_USERS),
		.ROW_W     (ROW_W)
	) u_write_tracker (
		.i_core_clk        (i_core_clk),
		.i_rx_rstn         (i_rx_rstn),
		.i_rdm_slot_start  (i_rdm_slot_start),
		.i_start_offset    (start_offset),
		.i_start_load      (start_load),
		.i_users_e0_sz     (i_users_e0_sz),
		.i_users_e1_sz     (i_users_e1_sz),
		.i_users_e0_num    (i_users_e0_num),
		.i_layer_indicator (i_layer_indicator),
		.i_demux_strb      (i_demux_strb),
		.i_demux_user_idx  (i_demux_user_idx),
		.o_wr_strb         (wr_strb),
		.o_wr_row          (wr_row),
		.o_wr_bank_sel     (wr_bank_sel),
		.o_ping_pong       (o_ping_pong),
		.o_cb_done         (o_cb_done),
		.o_cb_user         (o_cb_user),
		.o_cb_size         (o_cb_size)
	);

	rdm_write_formatter #(
		.NUM_USERS (NUM_USERS),
		.ROW_W     (ROW_W)
	) u_write_formatter (
		.i_wr_strb         (wr_strb),
		.i_wr_row          (wr_row),
		.i_wr_bank_sel     (wr_bank_sel),
		.i_demux_user_idx  (i_demux_user_idx),
		.i_demux_rx        (i_demux_rx),
		.i_layer_indicator (i_layer_indicator),
		.i_users_qm        (i_users_qm),
		.o_bank_we         (bank_we),
		.o_bank_row        (bank_row),
		.o_bank_data       (bank_data)
	);

	// Output side
	rdm_input_buffer #(
		.ROW_W (ROW_W)
	) u_input_buffer (
		.i_core_clk  (i_core_clk),
		.i_bank_we   (bank_we),
		.i_bank_row  (bank_row),
		.i_bank_data (bank_data),
		.i_rd_row    (i_rd_row),
		.o_rd_data   (o_rd_data)
	);

endmodule

// ==== verification/rdm_tb.sv ====
// Needs NUM_USERS 8 and ROW_W 11. Unwritten buffer words are taken from a baseline read at start
module rdm_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rdm_pkg::*;

	localparam int NUM_USERS = 8;
	localparam int ROW_W     = 11;
	localparam int ROWS      = 2**ROW_W;
	localparam int SLOT_GAP  = 12;   // Cycles from slot start to first strobe
	localparam int P2_STROBES = 300;
	localparam int P3_STROBES = 240;
	localparam int P4_STROBES = 400;
	localparam int P5_STROBES = 200;
	localparam int STROBES_TOTAL = NUM_USERS + P2_STROBES + P3_STROBES + P4_STROBES + P5_STROBES;
	localparam int READ_CYCLES   = (6 * ROWS + NUM_USERS) * 2;   // Baseline plus five sweeps
	localparam int WATCHDOG_NS   = (STROBES_TOTAL + READ_CYCLES + 2000) * 10;

	// User 0 in the low bits
	localparam logic [31:0] QM_SET     = {4'd2, 4'd6, 4'd3, 4'd8, 4'd6, 4'd4, 4'd2, 4'd1};
	localparam logic [63:0] E0_SZ_SET  = {8'd8, 8'd2, 8'd6, 8'd5, 8'd9, 8'd3, 8'd7, 8'd4};
	localparam logic [63:0] E0_NUM_SET = {8'd2, 8'd3, 8'd1, 8'd2, 8'd0, 8'd3, 8'd2, 8'd1};
	localparam logic [7:0]  LAYER_SET  = 8'b1010_0110;

	typedef struct packed {
		logic      pp;
		user_idx_t user;
		addr_t     size;
	} cb_exp_t;

	logic                    core_clk = 1'b0;
	logic                    rx_rstn;
	logic                    slot_start;
	size_t   [NUM_USERS-1:0] e0_sz;
	size_t   [NUM_USERS-1:0] e1_sz;
	cb_cnt_t [NUM_USERS-1:0] e0_num;
	logic    [NUM_USERS-1:0] layer;
	qm_t     [NUM_USERS-1:0] qm;
	logic                    demux_strb;
	user_idx_t               demux_user_idx;
	logic [DEMUX_W-1:0]      demux_rx;
	logic [ROW_W-1:0]        rd_row;
	row_data_t               rd_data;
	logic [NUM_USERS-1:0]    ping_pong;
	logic                    cb_done;
	user_idx_t               cb_user;
	addr_t                   cb_size;

	// Model state
	bank_word_t              model_mem [ROWS][BANK_NUM];
	addr_t                   m_cnt [NUM_USERS];
	addr_t                   m_tot [NUM_USERS];
	cb_cnt_t                 m_cb [NUM_USERS];
	logic [NUM_USERS-1:0]    m_pp;
	cb_exp_t                 exp_cb_q [$];
	bank_word_t              first_word [NUM_USERS];
	logic [31:0]             rand_state = 32'hf9fc;
	int                      mismatch_cnt = 0;
	int                      other_cnt = 0;

	rdm_input_top #(
		.NUM_USERS (NUM_USERS),
		.ROW_W     (ROW_W)
	) i_rdm_input_top (
		.i_core_clk        (core_clk),
		.i_rx_rstn         (rx_rstn),
		.i_rdm_slot_start  (slot_start),
		.i_users_e0_sz     (e0_sz),
		.i_users_e1_sz     (e1_sz),
		.i_users_e0_num    (e0_num),
		.i_layer_indicator (layer),
		.i_users_qm        (qm),
		.i_demux_strb      (demux_strb),
		.i_demux_user_idx  (demux_user_idx),
		.i_demux_rx        (demux_rx),
		.i_rd_row          (rd_row),
		.o_rd_data         (rd_data),
		.o_ping_pong       (ping_pong),
		.o_cb_done         (cb_done),
		.o_cb_user         (cb_user),
		.o_cb_size         (cb_size)
	);

	always #5 core_clk = ~core_clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Each earlier user takes its E1 size rounded up to whole rows
	function automatic addr_t calc_offset(input int u);
		addr_t off;
		off = '0;
		for (int k = 0; k < u; k++)
			off = off + addr_t'((e1_sz[k][15:4] + 1) * 16);
		return off;
	endfunction

	function automatic void model_apply(input int u, input logic [DEMUX_W-1:0] rx);
		int         row;
		int         bank;
		int         lw;
		size_t      lim;
		bank_word_t lo;
		bank_word_t hi;
		cb_exp_t    e;
		if (u >= NUM_USERS)
			return;   // Out-of-range user writes nothing
		row  = {m_pp[u], m_tot[u][13:4]};
		bank = m_tot[u][3:0];
		if (!layer[u])
			model_mem[row][bank] = rx[BANK_DATA_W-1:0];
		else
		begin
			lo = '0;
			hi = '0;
			case (qm[u])
				4'd1, 4'd2, 4'd4, 4'd6, 4'd8: lw = LLR_W * qm[u];
				default: lw = 0;
			endcase
			for (int i = 0; i < lw; i++)
			begin
				lo[i] = rx[i];
				hi[i] = rx[lw + i];
			end
			model_mem[row][bank & 14] = lo;
			model_mem[row][bank | 1]  = hi;
		end
		lim = (m_cb[u] < e0_num[u]) ? e0_sz[u] : e1_sz[u];
		if (size_t'(m_cnt[u]) >= lim)
		begin
			m_pp[u] = ~m_pp[u];
			e.pp    = m_pp[u];
			e.user  = user_idx_t'(u);
			e.size  = m_cnt[u];
			exp_cb_q.push_back(e);
			m_cnt[u] = '0;
			m_tot[u] = calc_offset(u);
			m_cb[u]  = m_cb[u] + 1'b1;
		end
		else
		begin
			m_cnt[u] = m_cnt[u] + (layer[u] ? 2 : 1);
			m_tot[u] = m_tot[u] + (layer[u] ? 2 : 1);
		end
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic report_mismatch(input string msg);
		mismatch_cnt++;
		$display("mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic configure(input int phase);
		@(posedge core_clk);
		for (int u = 0; u < NUM_USERS; u++)
		begin
			e1_sz[u] <= size_t'(20 + 37 * u);
			case (phase)
				1:
				begin
					e0_sz[u]  <= size_t'(6 + 2 * u);
					e0_num[u] <= 8'd2;
					layer[u]  <= 1'b0;
					qm[u]     <= 4'd2;
				end
				3:
				begin
					layer[u] <= 1'b1;
					qm[u]    <= QM_SET[u*4 +: 4];
				end
				default:
				begin
					e0_sz[u]  <= size_t'(E0_SZ_SET[u*8 +: 8]);
					e0_num[u] <= E0_NUM_SET[u*8 +: 8];
					layer[u]  <= LAYER_SET[u];
					qm[u]     <= 4'd4;
				end
			endcase
		end
	endtask

	task automatic start_slot();
		@(posedge core_clk);
		slot_start <= 1'b1;
		@(posedge core_clk);
		slot_start <= 1'b0;
		for (int u = 0; u < NUM_USERS; u++)
		begin
			m_cnt[u] = '0;
			m_cb[u]  = '0;
			m_tot[u] = calc_offset(u);
		end
		repeat (SLOT_GAP) @(posedge core_clk);
	endtask

	task automatic strobe_one(input int u, input logic [DEMUX_W-1:0] rx);
		@(posedge core_clk);
		demux_strb     <= 1'b1;
		demux_user_idx <= user_idx_t'(u);
		demux_rx       <= rx;
		model_apply(u, rx);
	endtask

	task automatic drive_strobes(input int count, input int span);
		int                 u;
		logic [DEMUX_W-1:0] rx;
		for (int n = 0; n < count; n++)
		begin
			u  = int'(next_rand() >> 16) % span;
			rx = {next_rand(), next_rand(), next_rand()};
			strobe_one(u, rx);
		end
	endtask

	task automatic end_strobes();
		@(posedge core_clk);
		demux_strb <= 1'b0;
		repeat (3) @(posedge core_clk);
		if (exp_cb_q.size() != 0)
		begin
			other_cnt++;
			$display("%0d code block completions were never reported", exp_cb_q.size());
			exp_cb_q.delete();
		end
		if (ping_pong !== m_pp)
			report_mismatch($sformatf("ping-pong %b expected %b", ping_pong, m_pp));
	endtask

	// One cycle of read latency
	task automatic read_row(input int row, output row_data_t data);
		@(posedge core_clk);
		rd_row <= row[ROW_W-1:0];
		@(posedge core_clk);
		@(negedge core_clk);
		data = rd_data;
	endtask

	task automatic read_baseline();
		row_data_t data;
		for (int r = 0; r < ROWS; r++)
		begin
			read_row(r, data);
			for (int b = 0; b < BANK_NUM; b++)
				model_mem[r][b] = data[b*BANK_DATA_W +: BANK_DATA_W];
		end
	endtask

	task automatic check_rows();
		row_data_t  data;
		bank_word_t word;
		for (int r = 0; r < ROWS; r++)
		begin
			read_row(r, data);
			for (int b = 0; b < BANK_NUM; b++)
			begin
				word = data[b*BANK_DATA_W +: BANK_DATA_W];
				if (word !== model_mem[r][b])
					report_mismatch($sformatf("row %0d bank %0d read %h expected %h",
						r, b, word, model_mem[r][b]));
			end
		end
	endtask

	task automatic check_first_offsets();
		addr_t      off;
		row_data_t  data;
		bank_word_t word;
		for (int u = 0; u < NUM_USERS; u++)
		begin
			off = calc_offset(u);
			read_row({1'b0, off[13:4]}, data);   // Half 0 after reset
			word = data[off[3:0]*BANK_DATA_W +: BANK_DATA_W];
			if (word !== first_word[u])
				report_mismatch($sformatf("user %0d first word %h at offset %0d expected %h",
					u, word, off, first_word[u]));
		end
	endtask

	//////////////////////////////
	// Completion compare
	//////////////////////////////

	always @(negedge core_clk)
	begin
		cb_exp_t e;
		if (rx_rstn && cb_done)
		begin
			if (exp_cb_q.size() == 0)
			begin
				other_cnt++;
				$display("completion reported at %0t ns when none was due", $time);
			end
			else
			begin
				e = exp_cb_q.pop_front();
				if (cb_user !== e.user || cb_size !== e.size)
					report_mismatch($sformatf("completion user %0d size %0d expected %0d %0d",
						cb_user, cb_size, e.user, e.size));
				if (ping_pong[e.user] !== e.pp)
					report_mismatch($sformatf("ping-pong of user %0d not toggled", e.user));
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		logic [DEMUX_W-1:0] rx;
		rx_rstn        = 1'b0;
		slot_start     = 1'b0;
		e0_sz          = '0;
		e1_sz          = '0;
		e0_num         = '0;
		layer          = '0;
		qm             = '0;
		demux_strb     = 1'b0;
		demux_user_idx = '0;
		demux_rx       = '0;
		rd_row         = '0;
		m_pp           = '0;
		repeat (3) @(posedge core_clk);
		rx_rstn <= 1'b1;
		read_baseline();

		// Base offsets, one element per user
		configure(1);
		start_slot();
		for (int u = 0; u < NUM_USERS; u++)
		begin
			rx            = {next_rand(), next_rand(), next_rand()};
			first_word[u] = rx[BANK_DATA_W-1:0];
			strobe_one(u, rx);
		end
		end_strobes();
		check_first_offsets();
		check_rows();

		drive_strobes(P2_STROBES, NUM_USERS);   // One layer, same slot
		end_strobes();
		check_rows();

		configure(3);   // Two layers, every qm
		start_slot();
		drive_strobes(P3_STROBES, NUM_USERS);
		end_strobes();
		check_rows();

		configure(4);
		start_slot();
		drive_strobes(P4_STROBES, 4);   // Few users so E1 blocks are reached
		end_strobes();
		check_rows();

		// Restart keeps ping-pong, indexes 8 to 15 are dropped
		start_slot();
		if (ping_pong !== m_pp)
			report_mismatch($sformatf("ping-pong %b after restart expected %b", ping_pong, m_pp));
		drive_strobes(P5_STROBES, 16);
		end_strobes();
		check_rows();

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
design/rdm_pkg.sv
design/rdm_start_calc.sv
design/rdm_write_tracker.sv
design/rdm_write_formatter.sv
design/rdm_input_buffer.sv
design/rdm_input_top.sv
verification/rdm_tb.sv

// ==== Bender.yml ====
package:
  name: rdm_input

sources:
  - files:
      - design/rdm_pkg.sv
      - design/rdm_start_calc.sv
      - design/rdm_write_tracker.sv
      - design/rdm_write_formatter.sv
      - design/rdm_input_buffer.sv
      - design/rdm_input_top.sv

  - target: simulation
    files:
      - verification/rdm_tb.sv
